// File: hw/maxi_io_config.svh
// Address map, register offsets and sizes for the bus subsystem, included by decoder and devices
`ifndef MAXI_IO_CONFIG_SVH
`define MAXI_IO_CONFIG_SVH

// Device classes in the high byte of the byte address
`define MAXI_MEM_CLASS 8'h00
`define MAXI_IO_CLASS 8'h0F

// Tone generator word indices, byte address bits 7 to 2 of the I/O class
`define MAXI_REG_TONE_PERIOD 6'd1
`define MAXI_REG_TONE_DURATION 6'd2
`define MAXI_REG_TONE_STATUS 6'd3

// Program RAM depth in 32-bit words, must be a power of two
`define MAXI_MEM_WORDS 256

// Width of the tone period and duration counters
`define MAXI_TONE_WIDTH 16

`endif

// File: hw/maxi_io_pkg.sv
// Bus request, read response and device select types shared by all bus subsystem modules
package maxi_io_pkg;

    // One bus cycle from the master
    // Address is the word address, byte address bits 31 to 2
    typedef struct packed {
        logic [29:0] address;
        logic [31:0] data;
        logic [3:0]  strobes;
        logic        read;
        logic        write;
    } bus_req_t;

    // Registered read return from one device
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } rd_resp_t;

    // Device selects, at most one set at a time
    typedef struct packed {
        logic mem_cs;
        logic tone_period_cs;
        logic tone_duration_cs;
        logic tone_status_cs;
    } dev_sel_t;

endpackage

// File: hw/addr_decode.sv
// Address decoder, turns a bus request into device selects and flags unmapped strobes
`timescale 1ns/1ps
`include "maxi_io_config.svh"

module addr_decode (
    input  logic                  clock,
    input  logic                  rst_n,
    input  maxi_io_pkg::bus_req_t req,
    output maxi_io_pkg::dev_sel_t sel,
    output logic                  bus_error
);
    import maxi_io_pkg::*;

    // Device class is the high byte of the byte address
    logic [7:0] dev_class;
    // Register word index inside the low byte
    logic [5:0] reg_index;
    logic       is_io;
    dev_sel_t   dec;

    assign dev_class = req.address[29:22];
    assign reg_index = req.address[5:0];
    assign is_io     = (dev_class == `MAXI_IO_CLASS);

    // RAM takes the whole memory class and aliases above its depth
    always_comb begin
        dec.mem_cs           = (dev_class == `MAXI_MEM_CLASS);
        dec.tone_period_cs   = is_io && (reg_index == `MAXI_REG_TONE_PERIOD);
        dec.tone_duration_cs = is_io && (reg_index == `MAXI_REG_TONE_DURATION);
        dec.tone_status_cs   = is_io && (reg_index == `MAXI_REG_TONE_STATUS);
    end

    assign sel = dec;

    // A strobe that hits no device gives a one-cycle error pulse
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            bus_error <= 1'b0;
        end else begin
            bus_error <= (req.read || req.write) && (dec == '0);
        end
    end

    // Class and offset compares must never overlap
    a_sel_onehot: assert property (@(posedge clock) disable iff (!rst_n) $onehot0(sel))
        else $error("addr_decode: several devices selected at once");

endmodule

// File: hw/bus_memory.sv
// Program RAM on the bus, byte-strobed writes and one-cycle registered reads
`timescale 1ns/1ps
`include "maxi_io_config.svh"

module bus_memory (
    input  logic                  clock,
    input  logic                  rst_n,
    input  maxi_io_pkg::bus_req_t req,
    input  logic                  cs,
    output maxi_io_pkg::rd_resp_t resp
);
    localparam int index_bits = $clog2(`MAXI_MEM_WORDS);

    logic [31:0]           mem [`MAXI_MEM_WORDS];
    logic [index_bits-1:0] index;
    logic                  resp_valid;
    logic [31:0]           resp_data;

    assign index = req.address[index_bits-1:0];

    // Only lanes with their strobe set are written
    always_ff @(posedge clock) begin
        if (cs && req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req.strobes[b]) begin
                    mem[index][8*b +: 8] <= req.data[8*b +: 8];
                end
            end
        end
    end

    // Read returns the word from before a same-cycle write
    always_ff @(posedge clock) begin
        if (cs && req.read) begin
            resp_data <= mem[index];
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= cs && req.read;
        end
    end

    assign resp.valid = resp_valid;
    assign resp.data  = resp_data;

    a_no_rd_wr: assert property (@(posedge clock) disable iff (!rst_n)
        cs |-> !(req.read && req.write))
        else $error("bus_memory: read and write in the same cycle");

endmodule

// File: hw/tonegen_interface.sv
// Tone generator peripheral, period and duration registers driving the buzzer pin
`timescale 1ns/1ps
`include "maxi_io_config.svh"

module tonegen_interface (
    input  logic                  clock,
    input  logic                  rst_n,
    input  maxi_io_pkg::bus_req_t req,
    input  maxi_io_pkg::dev_sel_t sel,
    output maxi_io_pkg::rd_resp_t resp,
    output logic                  buzzer
);
    import maxi_io_pkg::*;

    localparam int width = `MAXI_TONE_WIDTH;

    logic [width-1:0] period;
    // Remaining tone cycles, nonzero while busy
    logic [width-1:0] countdown;
    // Cycles since the last buzzer edge
    logic [width-1:0] phase;
    logic             busy;
    logic             wr_period;
    logic             wr_duration;
    logic             rd_hit;
    rd_resp_t         rd_next;
    logic             resp_valid;
    logic [31:0]      resp_data;

    assign busy        = (countdown != '0);
    assign wr_period   = req.write && sel.tone_period_cs;
    assign wr_duration = req.write && sel.tone_duration_cs;
    assign rd_hit      = req.read
                         && (sel.tone_period_cs || sel.tone_duration_cs || sel.tone_status_cs);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            period <= '0;
        end else if (wr_period) begin
            period <= req.data[width-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            countdown <= '0;
            phase     <= '0;
            buzzer    <= 1'b0;
        end else if (wr_duration) begin
            // New duration restarts the tone from a low buzzer
            countdown <= req.data[width-1:0];
            phase     <= '0;
            buzzer    <= 1'b0;
        end else if (busy) begin
            countdown <= countdown - 1'b1;
            if (countdown == width'(1)) begin
                // Last cycle, buzzer drops with busy
                phase  <= '0;
                buzzer <= 1'b0;
            end else if (period == '0) begin
                buzzer <= 1'b0;
            end else if (phase >= period - 1'b1) begin
                phase  <= '0;
                buzzer <= ~buzzer;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // Register readback, status holds busy in bit 0
    always_comb begin
        rd_next.valid = rd_hit;
        if (sel.tone_period_cs) begin
            rd_next.data = 32'(period);
        end else if (sel.tone_duration_cs) begin
            rd_next.data = 32'(countdown);
        end else begin
            rd_next.data = 32'(busy);
        end
    end

    always_ff @(posedge clock) begin
        if (rd_hit) begin
            resp_data <= rd_next.data;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= rd_next.valid;
        end
    end

    assign resp.valid = resp_valid;
    assign resp.data  = resp_data;

    a_quiet_idle: assert property (@(posedge clock) disable iff (!rst_n) !busy |-> !buzzer)
        else $error("tonegen_interface: buzzer high while idle");

endmodule

// File: hw/data_in_mux.sv
// Read return mux, forwards whichever device response is valid to the bus master
`timescale 1ns/1ps

module data_in_mux (
    input  logic                  rst_n,
    input  maxi_io_pkg::rd_resp_t mem_resp,
    input  maxi_io_pkg::rd_resp_t tone_resp,
    output maxi_io_pkg::rd_resp_t rd_data
);

    // Selected by valid alone, no address is looked at here
    always_comb begin
        if (mem_resp.valid) begin
            rd_data = mem_resp;
        end else if (tone_resp.valid) begin
            rd_data = tone_resp;
        end else begin
            rd_data = '0;
        end
    end

    // Reads are serialized by the master, so two returns never meet
    always_comb begin
        if (rst_n) begin
            a_single_resp: assert (!(mem_resp.valid && tone_resp.valid))
                else $error("data_in_mux: two read responses in one cycle");
        end
    end

endmodule

// File: hw/maxi_io_top.sv
// Bus subsystem top, decoder, program RAM, tone generator and read return mux
`timescale 1ns/1ps

module maxi_io_top (
    input  logic                  clock,
    input  logic                  rst_n,
    input  maxi_io_pkg::bus_req_t req,
    output maxi_io_pkg::rd_resp_t rd_data,
    output logic                  bus_error,
    output logic                  buzzer
);
    import maxi_io_pkg::*;

    dev_sel_t sel;
    // Registered returns from each device
    rd_resp_t mem_resp;
    rd_resp_t tone_resp;

    addr_decode u_addr_decode (
        .clock     (clock),
        .rst_n     (rst_n),
        .req       (req),
        .sel       (sel),
        .bus_error (bus_error)
    );

    // Program memory
    bus_memory u_bus_memory (
        .clock (clock),
        .rst_n (rst_n),
        .req   (req),
        .cs    (sel.mem_cs),
        .resp  (mem_resp)
    );

    tonegen_interface u_tonegen_interface (
        .clock  (clock),
        .rst_n  (rst_n),
        .req    (req),
        .sel    (sel),
        .resp   (tone_resp),
        .buzzer (buzzer)
    );

    data_in_mux u_data_in_mux (
        .rst_n     (rst_n),
        .mem_resp  (mem_resp),
        .tone_resp (tone_resp),
        .rd_data   (rd_data)
    );

endmodule

// File: verification/maxi_io_tb.sv
// Testbench for the bus subsystem that plays the bus master and checks responses with assertions
`timescale 1ns/1ps
`include "maxi_io_config.svh"

module maxi_io_tb;
    import maxi_io_pkg::*;

    localparam int index_bits = $clog2(`MAXI_MEM_WORDS);
    localparam int width = `MAXI_TONE_WIDTH;
    localparam int cycle_limit = 4000;

    logic     clock;
    logic     rst_n;
    bus_req_t req;
    rd_resp_t rd_data;
    logic     bus_error;
    logic     buzzer;

    // Reference RAM and expected registered outputs
    logic [31:0]           ref_mem [`MAXI_MEM_WORDS];
    logic                  exp_valid;
    logic [31:0]           exp_data;
    logic                  exp_err;
    logic                  exp_is_status;
    // Shadow tone state where tone_t counts cycles since the duration write
    logic [width-1:0]      sh_period;
    logic [width-1:0]      sh_count;
    logic [width-1:0]      tone_t;
    logic [width-1:0]      tone_steps;
    logic                  exp_buzz;
    logic [7:0]            req_class;
    logic [5:0]            req_reg;
    logic [index_bits-1:0] req_index;
    logic                  hit_mem;
    logic                  hit_tone;
    logic [31:0]           rng_state;
    int                    read_errors;
    int                    bus_errors;
    int                    tone_errors;
    int                    busy_seen;
    int                    cycle_count;

    maxi_io_top u_dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .req       (req),
        .rd_data   (rd_data),
        .bus_error (bus_error),
        .buzzer    (buzzer)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    assign req_class = req.address[29:22];
    assign req_reg   = req.address[5:0];
    assign req_index = req.address[index_bits-1:0];
    assign hit_mem   = (req_class == `MAXI_MEM_CLASS);
    assign hit_tone  = (req_class == `MAXI_IO_CLASS)
                       && ((req_reg == `MAXI_REG_TONE_PERIOD)
                       || (req_reg == `MAXI_REG_TONE_DURATION)
                       || (req_reg == `MAXI_REG_TONE_STATUS));

    // Buzzer level follows the number of whole periods since the start
    assign tone_steps = (sh_period != '0) ? (tone_t / sh_period) : '0;
    assign exp_buzz   = (sh_count != '0) && tone_steps[0];

    always @(posedge clock) begin
        if (!rst_n) begin
            exp_valid     <= 1'b0;
            exp_err       <= 1'b0;
            exp_is_status <= 1'b0;
            sh_period     <= '0;
            sh_count      <= '0;
            tone_t        <= '0;
            busy_seen     <= 0;
        end else begin
            exp_valid     <= req.read && (hit_mem || hit_tone);
            exp_err       <= (req.read || req.write) && !(hit_mem || hit_tone);
            exp_is_status <= req.read && hit_tone && (req_reg == `MAXI_REG_TONE_STATUS);
            if (req.read) begin
                if (hit_mem) begin
                    exp_data <= ref_mem[req_index];
                end else if (req_reg == `MAXI_REG_TONE_PERIOD) begin
                    exp_data <= 32'(sh_period);
                end else if (req_reg == `MAXI_REG_TONE_DURATION) begin
                    exp_data <= 32'(sh_count);
                end else begin
                    exp_data <= {31'd0, (sh_count != '0)};
                end
            end
            if (req.write && hit_mem) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.strobes[b]) begin
                        ref_mem[req_index][8*b +: 8] <= req.data[8*b +: 8];
                    end
                end
            end
            if (req.write && hit_tone && (req_reg == `MAXI_REG_TONE_PERIOD)) begin
                sh_period <= req.data[width-1:0];
            end
            if (req.write && hit_tone && (req_reg == `MAXI_REG_TONE_DURATION)) begin
                sh_count <= req.data[width-1:0];
                tone_t   <= '0;
            end else if (sh_count != '0) begin
                sh_count <= sh_count - width'(1);
                tone_t   <= tone_t + width'(1);
            end
            if (exp_valid && exp_is_status && rd_data.data[0]) begin
                busy_seen <= busy_seen + 1;
            end
        end
    end

    a_valid_timing: assert property (@(posedge clock) disable iff (!rst_n)
        rd_data.valid == exp_valid)
        else begin
            read_errors++;
            $display("ERROR %0t ns: rd_data.valid is %0b, expected %0b",
                     $time, rd_data.valid, exp_valid);
        end

    a_read_data: assert property (@(posedge clock) disable iff (!rst_n)
        exp_valid |-> (rd_data.data == exp_data))
        else begin
            read_errors++;
            $display("ERROR %0t ns: read data %h, expected %h", $time, rd_data.data, exp_data);
        end

    a_bus_error: assert property (@(posedge clock) disable iff (!rst_n) bus_error == exp_err)
        else begin
            bus_errors++;
            $display("ERROR %0t ns: bus_error is %0b, expected %0b", $time, bus_error, exp_err);
        end

    a_buzzer: assert property (@(posedge clock) disable iff (!rst_n) buzzer == exp_buzz)
        else begin
            tone_errors++;
            $display("ERROR %0t ns: buzzer is %0b, expected %0b", $time, buzzer, exp_buzz);
        end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("The run timed out after %0d cycles without finishing the tests",
                     cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [29:0] mem_addr(input int idx);
        return {`MAXI_MEM_CLASS, 22'(idx)};
    endfunction

    function automatic logic [29:0] io_addr(input logic [5:0] reg_sel);
        return {`MAXI_IO_CLASS, 16'd0, reg_sel};
    endfunction

    // Foreign class or unused I/O offset whose low bits alias RAM words
    function automatic logic [29:0] unmapped_addr(input logic [31:0] r);
        logic [7:0] cls;
        cls = r[23:16];
        if (r[24]) begin
            return {`MAXI_IO_CLASS, r[31:16], r[13:8] | 6'd4};
        end
        if ((cls == `MAXI_MEM_CLASS) || (cls == `MAXI_IO_CLASS)) begin
            cls = 8'h80;
        end
        return {cls, r[31:10]};
    endfunction

    // All bus tasks start and end on a falling edge
    task automatic write_word(input logic [29:0] addr, input logic [31:0] data,
                              input logic [3:0] strobes);
        req.address = addr;
        req.data    = data;
        req.strobes = strobes;
        req.read    = 1'b0;
        req.write   = 1'b1;
        @(negedge clock);
        req.write = 1'b0;
    endtask

    task automatic read_word(input logic [29:0] addr);
        req.address = addr;
        req.read    = 1'b1;
        req.write   = 1'b0;
        @(negedge clock);
        req.read = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clock);
    endtask

    task automatic wait_tone_idle();
        do begin
            read_word(io_addr(`MAXI_REG_TONE_STATUS));
        end while (rd_data.data[0]);
    endtask

    // Busy must be seen on exactly duration consecutive status polls
    task automatic play_tone(input int period, input int duration);
        int start;
        write_word(io_addr(`MAXI_REG_TONE_PERIOD), 32'(period), 4'hF);
        start = busy_seen;
        write_word(io_addr(`MAXI_REG_TONE_DURATION), 32'(duration), 4'hF);
        wait_tone_idle();
        a_busy_length: assert (busy_seen - start == duration)
            else begin
                tone_errors++;
                $display("ERROR %0t ns: busy for %0d polls, expected %0d",
                         $time, busy_seen - start, duration);
            end
        idle_cycles(3);
    endtask

    task automatic tone_readback(input int period, input int duration);
        write_word(io_addr(`MAXI_REG_TONE_PERIOD), 32'(period), 4'hF);
        write_word(io_addr(`MAXI_REG_TONE_DURATION), 32'(duration), 4'hF);
        idle_cycles(duration / 3);
        read_word(io_addr(`MAXI_REG_TONE_PERIOD));
        read_word(io_addr(`MAXI_REG_TONE_DURATION));
        idle_cycles(duration / 4);
        read_word(io_addr(`MAXI_REG_TONE_DURATION));
        wait_tone_idle();
        idle_cycles(3);
    endtask

    initial begin
        logic [31:0] r;
        req         = '0;
        rst_n       = 1'b0;
        rng_state   = 32'd18;
        read_errors = 0;
        bus_errors  = 0;
        tone_errors = 0;
        cycle_count = 0;
        repeat (3) @(negedge clock);
        rst_n = 1'b1;
        // Quiet outputs before the first strobe
        idle_cycles(6);

        for (int i = 0; i < `MAXI_MEM_WORDS; i++) begin
            write_word(mem_addr(i), next_random() ^ {24'd0, 8'(i)}, 4'hF);
        end
        for (int i = 0; i < 900; i++) begin
            r = next_random();
            if (r[31]) begin
                read_word(mem_addr(int'(r[15:8])));
            end else begin
                write_word(mem_addr(int'(r[15:8])), next_random(), r[19:16]);
            end
        end
        for (int i = 0; i < `MAXI_MEM_WORDS; i++) begin
            read_word(mem_addr(i));
        end

        for (int i = 0; i < 60; i++) begin
            r = next_random();
            if (r[30]) begin
                read_word(unmapped_addr(r));
            end else begin
                write_word(unmapped_addr(r), next_random(), 4'hF);
            end
        end
        for (int i = 0; i < `MAXI_MEM_WORDS; i++) begin
            read_word(mem_addr(i));
        end

        play_tone(3, 40);
        play_tone(4, 16);
        tone_readback(5, 60);
        play_tone(0, 25);
        idle_cycles(4);

        $display("Error counts: read %0d, bus error %0d, tone %0d",
                 read_errors, bus_errors, tone_errors);
        if (read_errors + bus_errors + tone_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: maxi_io.f
+incdir+hw
hw/maxi_io_pkg.sv
hw/addr_decode.sv
hw/bus_memory.sv
hw/tonegen_interface.sv
hw/data_in_mux.sv
hw/maxi_io_top.sv
verification/maxi_io_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the bus subsystem testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module maxi_io_tb --Mdir "$build_dir" -f maxi_io.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/Vmaxi_io_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation failed" "$log_file"; then
    echo "Failure found in $log_file"
    exit 1
fi

echo "No failure found in $log_file"
exit 0
